//--- verification/program_patterns.txt
// word 0 program length, word 1 store count, then program words,
// then one line per expected store: test number, address, data
00000021 0000000B
123450B7 67808113 FFF14193 00310233
402202B3 00222333 0F017393 0063E433
00202023 00302223 00402423 00502623
00602823 00802A23
// load-use
00002483 00948533 00A02C23
// branches, flushed slots store to 0x20 with wrong data
00310463 00202E23 00311663 02302023
02402023 00210663 02502023 02502023
00211463 02702023
// jal over a store, then store the link
008005EF 02202223 02B02223
// write x0 and store it, then spin
05510013 02002423 0000006F
// expected stores
00000002 00000000 12345678
00000002 00000004 EDCBA987
00000002 00000008 FFFFFFFF
00000002 0000000C EDCBA987
00000002 00000010 00000001
00000002 00000014 00000071
00000003 00000018 2468ACF0
00000004 0000001C 12345678
00000004 00000020 00000070
00000005 00000024 00000070
00000006 00000028 00000000

//--- riscv_pipelined.f
+incdir+design
design/riscv_pkg.sv
design/pipe_register.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/hazard_unit.sv
design/write_back.sv
design/riscv_pipelined.sv
verification/riscv_pipelined_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module riscv_pipelined_tb \
  -f riscv_pipelined.f

./obj_dir/Vriscv_pipelined_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log; then
  exit 1
fi
exit 0

//--- verification/riscv_pipelined_tb.sv
`timescale 1ns/1ps
`include "riscv_settings.svh"

// testbench for the five-stage core
// program and expected stores come from a pattern file
module riscv_pipelined_tb;

  localparam int PAT_WORDS = 256;
  localparam int MEM_WORDS = 64;

  logic        clk;
  logic        reset;
  logic [31:0] memory_instr__address;
  logic [31:0] memory_instr__read_data;
  logic [31:0] memory_data__address;
  logic [31:0] memory_data__write_data;
  logic [3:0]  memory_data__write_enable;
  logic [31:0] memory_data__read_data;

  logic [31:0] pat [PAT_WORDS];
  logic [31:0] imem [MEM_WORDS];
  logic [31:0] dmem [MEM_WORDS];
  int          n_prog;
  int          n_stores;
  int          store_base;
  int          store_idx;
  int          errors;
  int          group_errors;
  int          groups_passed;
  int          groups_failed;
  int          cycles;
  int          cycle_limit;
  logic        timed_out;

  riscv_pipelined DUT (
      .clk                       (clk)
    , .reset                     (reset)
    , .memory_instr__address     (memory_instr__address)
    , .memory_instr__read_data   (memory_instr__read_data)
    , .memory_data__address      (memory_data__address)
    , .memory_data__write_data   (memory_data__write_data)
    , .memory_data__write_enable (memory_data__write_enable)
    , .memory_data__read_data    (memory_data__read_data)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // both memories read combinationally
  // fetches past the program return a nop
  assign memory_instr__read_data = (memory_instr__address[31:2] < n_prog) ?
                                   imem[memory_instr__address[7:2]] : 32'h0000_0013;
  assign memory_data__read_data  = dmem[memory_data__address[7:2]];

  function automatic string group_name(input int n);
    case (n)
      1:       return "reset behavior";
      2:       return "alu and immediates";
      3:       return "load-use";
      4:       return "branches";
      5:       return "jal";
      6:       return "x0 write";
      default: return "unknown group";
    endcase
  endfunction

  // one line per finished test and a fresh count for the next
  task automatic finish_group(input int n);
    if (group_errors == 0) begin
      $display("test %0d %s: passed", n, group_name(n));
      groups_passed++;
    end else begin
      $display("test %0d %s: failed with %0d mismatches", n, group_name(n), group_errors);
      groups_failed++;
    end
    group_errors = 0;
  endtask

  task automatic check_reset_state();
    assert (memory_instr__address == `RISCV_RESET_PC) else begin
      $display("FAILED memory_instr__address: got %h expected %h",
               memory_instr__address, `RISCV_RESET_PC);
      errors++;
      group_errors++;
    end
    assert (memory_data__write_enable == 4'h0) else begin
      $display("FAILED memory_data__write_enable: got %h expected %h",
               memory_data__write_enable, 4'h0);
      errors++;
      group_errors++;
    end
  endtask

  // cycle budget
  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      timed_out = 1'b1;
    end
  end

  // every store is compared with the next expected one
  always @(posedge clk) begin
    int t;
    if (!reset && memory_data__write_enable != 4'h0 && store_idx < n_stores) begin
      t = pat[store_base + 3 * store_idx];
      // whole-word stores only
      assert (memory_data__write_enable == 4'hF) else begin
        $display("FAILED memory_data__write_enable: got %h expected %h",
                 memory_data__write_enable, 4'hF);
        errors++;
        group_errors++;
      end
      assert (memory_data__address == pat[store_base + 3 * store_idx + 1]) else begin
        $display("FAILED memory_data__address: got %h expected %h",
                 memory_data__address, pat[store_base + 3 * store_idx + 1]);
        errors++;
        group_errors++;
      end
      assert (memory_data__write_data == pat[store_base + 3 * store_idx + 2]) else begin
        $display("FAILED memory_data__write_data: got %h expected %h",
                 memory_data__write_data, pat[store_base + 3 * store_idx + 2]);
        errors++;
        group_errors++;
      end
      // last store of its group closes the test
      if (store_idx == n_stores - 1 || pat[store_base + 3 * (store_idx + 1)] != t) begin
        finish_group(t);
      end
      store_idx++;
      dmem[memory_data__address[7:2]] = memory_data__write_data;
    end
  end

  initial begin
    reset        = 1'b1;
    errors       = 0;
    group_errors = 0;
    groups_passed = 0;
    groups_failed = 0;
    store_idx    = 0;
    cycles       = 0;
    timed_out    = 1'b0;
    cycle_limit  = 1000;
    void'($urandom(32));

    // header words, program, then test/address/data triples
    $readmemh("verification/program_patterns.txt", pat);
    n_prog      = pat[0];
    n_stores    = pat[1];
    store_base  = 2 + n_prog;
    cycle_limit = 8 * n_prog + 50;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = (i < n_prog) ? pat[2 + i] : 32'h0000_0013;
      dmem[i] = $urandom;
    end

    // test 1 checks inside reset and the first cycle out of it
    @(posedge clk);
    @(negedge clk);
    check_reset_state();
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_reset_state();
    finish_group(1);

    wait (store_idx == n_stores || timed_out);
    if (store_idx < n_stores) begin
      $display("timeout after %0d cycles, only %0d of %0d expected stores arrived",
               cycles, store_idx, n_stores);
      errors++;
      groups_failed++;
    end
    $display("summary: %0d tests passed, %0d tests failed, %0d errors",
             groups_passed, groups_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- design/riscv_pipelined.sv
`timescale 1ns/1ps

// five-stage pipelined rv32i core
module riscv_pipelined
  import riscv_pkg::*;
(
    input  logic       clk
  , input  logic       reset

  // instruction memory, read only
  , output addr_t      memory_instr__address
  , input  word_t      memory_instr__read_data

  // data memory, whole words only
  , output addr_t      memory_data__address
  , output word_t      memory_data__write_data
  , output logic [3:0] memory_data__write_enable
  , input  word_t      memory_data__read_data
);

  if_id_t   if_id_d;
  if_id_t   if_id_q;
  id_ex_t   id_ex_d;
  id_ex_t   id_ex_q;
  ex_mem_t  ex_mem_d;
  ex_mem_t  ex_mem_q;
  mem_wb_t  mem_wb_d;
  mem_wb_t  mem_wb_q;

  reg_idx_t   dec_rs1;
  reg_idx_t   dec_rs2;
  logic       branch_taken;
  addr_t      branch_target;
  logic [1:0] fwd_a;
  logic [1:0] fwd_b;
  logic       stall;
  logic       flush;
  word_t      wb_result;
  reg_idx_t   wb_rd;
  logic       wb_write;
  logic       ex_is_load;

  // fetch
  fetch_stage u_fetch_stage (
      .clk           (clk)
    , .reset         (reset)
    , .stall         (stall)
    , .branch_taken  (branch_taken)
    , .branch_target (branch_target)
    , .instr_address (memory_instr__address)
    , .instr_data    (memory_instr__read_data)
    , .if_id         (if_id_d)
  );

  pipe_register #(.payload_t(if_id_t)) u_if_id (
      .clk   (clk)
    , .reset (reset)
    , .stall (stall)
    , .flush (flush)
    , .d     (if_id_d)
    , .q     (if_id_q)
  );

  // decode
  decode_stage u_decode_stage (
      .clk       (clk)
    , .reset     (reset)
    , .if_id     (if_id_q)
    , .wb_write  (wb_write)
    , .wb_rd     (wb_rd)
    , .wb_result (wb_result)
    , .rs1       (dec_rs1)
    , .rs2       (dec_rs2)
    , .id_ex     (id_ex_d)
  );

  // load-use stall leaves a bubble in execute
  pipe_register #(.payload_t(id_ex_t)) u_id_ex (
      .clk   (clk)
    , .reset (reset)
    , .stall (1'b0)
    , .flush (flush || stall)
    , .d     (id_ex_d)
    , .q     (id_ex_q)
  );

  // execute
  execute_stage u_execute_stage (
      .id_ex         (id_ex_q)
    , .fwd_a         (fwd_a)
    , .fwd_b         (fwd_b)
    , .mem_result    (ex_mem_q.alu_result)
    , .wb_result     (wb_result)
    , .branch_taken  (branch_taken)
    , .branch_target (branch_target)
    , .ex_mem        (ex_mem_d)
  );

  pipe_register #(.payload_t(ex_mem_t)) u_ex_mem (
      .clk   (clk)
    , .reset (reset)
    , .stall (1'b0)
    , .flush (1'b0)
    , .d     (ex_mem_d)
    , .q     (ex_mem_q)
  );

  // memory access straight off ex/mem
  assign memory_data__address      = ex_mem_q.alu_result;
  assign memory_data__write_data   = ex_mem_q.store_data;
  assign memory_data__write_enable = {4{ex_mem_q.mem_write}};

  assign mem_wb_d.alu_result = ex_mem_q.alu_result;
  assign mem_wb_d.load_data  = memory_data__read_data;
  assign mem_wb_d.pc_plus4   = ex_mem_q.pc_plus4;
  assign mem_wb_d.rd         = ex_mem_q.rd;
  assign mem_wb_d.result_src = ex_mem_q.result_src;
  assign mem_wb_d.reg_write  = ex_mem_q.reg_write;

  pipe_register #(.payload_t(mem_wb_t)) u_mem_wb (
      .clk   (clk)
    , .reset (reset)
    , .stall (1'b0)
    , .flush (1'b0)
    , .d     (mem_wb_d)
    , .q     (mem_wb_q)
  );

  // write-back
  write_back u_write_back (
      .mem_wb (mem_wb_q)
    , .result (wb_result)
    , .rd     (wb_rd)
    , .write  (wb_write)
  );

  // hazards
  assign ex_is_load = id_ex_q.reg_write && (id_ex_q.result_src == RES_LOAD);

  hazard_unit u_hazard_unit (
      .rs1           (dec_rs1)
    , .rs2           (dec_rs2)
    , .ex_rs1        (id_ex_q.rs1)
    , .ex_rs2        (id_ex_q.rs2)
    , .ex_rd         (id_ex_q.rd)
    , .ex_is_load    (ex_is_load)
    , .mem_rd        (ex_mem_q.rd)
    , .mem_write_reg (ex_mem_q.reg_write)
    , .wb_rd         (wb_rd)
    , .wb_write_reg  (wb_write)
    , .branch_taken  (branch_taken)
    , .fwd_a         (fwd_a)
    , .fwd_b         (fwd_b)
    , .stall         (stall)
    , .flush         (flush)
  );

endmodule

//--- design/write_back.sv
`timescale 1ns/1ps

// result select and register write strobe
module write_back
  import riscv_pkg::*;
(
    input  mem_wb_t  mem_wb
  , output word_t    result
  , output reg_idx_t rd
  , output logic     write
);

  always_comb begin
    case (mem_wb.result_src)
      RES_LOAD:     result = mem_wb.load_data;
      RES_PC_PLUS4: result = mem_wb.pc_plus4;
      default:      result = mem_wb.alu_result;
    endcase
  end

  assign rd = mem_wb.rd;

  // x0 is never written
  assign write = mem_wb.reg_write && (mem_wb.rd != '0);

endmodule

//--- design/hazard_unit.sv
`timescale 1ns/1ps

// forwarding selects, load-use stall, taken-branch flush
module hazard_unit
  import riscv_pkg::*;
(
    input  reg_idx_t   rs1
  , input  reg_idx_t   rs2
  , input  reg_idx_t   ex_rs1
  , input  reg_idx_t   ex_rs2
  , input  reg_idx_t   ex_rd
  , input  logic       ex_is_load
  , input  reg_idx_t   mem_rd
  , input  logic       mem_write_reg
  , input  reg_idx_t   wb_rd
  , input  logic       wb_write_reg
  , input  logic       branch_taken
  , output logic [1:0] fwd_a
  , output logic [1:0] fwd_b
  , output logic       stall
  , output logic       flush
);

  // memory stage is younger, so it wins over write-back
  always_comb begin
    fwd_a = 2'b00;
    if (mem_write_reg && mem_rd != '0 && mem_rd == ex_rs1) begin
      fwd_a = 2'b10;
    end else if (wb_write_reg && wb_rd != '0 && wb_rd == ex_rs1) begin
      fwd_a = 2'b01;
    end
    fwd_b = 2'b00;
    if (mem_write_reg && mem_rd != '0 && mem_rd == ex_rs2) begin
      fwd_b = 2'b10;
    end else if (wb_write_reg && wb_rd != '0 && wb_rd == ex_rs2) begin
      fwd_b = 2'b01;
    end
  end

  // load data only exists after memory, hold decode one cycle
  assign stall = ex_is_load && ex_rd != '0 && (ex_rd == rs1 || ex_rd == rs2);

  // kill the two younger instructions in fetch and decode
  assign flush = branch_taken;

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps

// operand forwarding, alu and branch resolution
module execute_stage
  import riscv_pkg::*;
(
    input  id_ex_t     id_ex
  , input  logic [1:0] fwd_a
  , input  logic [1:0] fwd_b
  , input  word_t      mem_result
  , input  word_t      wb_result
  , output logic       branch_taken
  , output addr_t      branch_target
  , output ex_mem_t    ex_mem
);

  word_t src_a;
  word_t src_b_reg;
  word_t src_b;
  word_t alu_out;
  logic  equal;

  // select encoding: 00 register file, 01 write-back, 10 memory stage
  always_comb begin
    case (fwd_a)
      2'b10:   src_a = mem_result;
      2'b01:   src_a = wb_result;
      default: src_a = id_ex.rs1_data;
    endcase
    case (fwd_b)
      2'b10:   src_b_reg = mem_result;
      2'b01:   src_b_reg = wb_result;
      default: src_b_reg = id_ex.rs2_data;
    endcase
  end

  assign src_b = id_ex.alu_src ? id_ex.imm : src_b_reg;

  always_comb begin
    case (id_ex.alu_op)
      ALU_SUB: alu_out = src_a - src_b;
      ALU_AND: alu_out = src_a & src_b;
      ALU_OR:  alu_out = src_a | src_b;
      ALU_XOR: alu_out = src_a ^ src_b;
      ALU_SLT: alu_out = {31'b0, $signed(src_a) < $signed(src_b)};
      default: alu_out = src_a + src_b;
    endcase
  end

  // beq and bne compare the forwarded register values
  assign equal         = (src_a == src_b_reg);
  assign branch_taken  = id_ex.jump ||
                         (id_ex.branch && (id_ex.branch_ne ? !equal : equal));
  assign branch_target = id_ex.pc + id_ex.imm;

  // jal link value rides in the alu result too so forwarding sees it
  assign ex_mem.alu_result = id_ex.jump ? id_ex.pc_plus4 : alu_out;
  assign ex_mem.store_data = src_b_reg;
  assign ex_mem.pc_plus4   = id_ex.pc_plus4;
  assign ex_mem.rd         = id_ex.rd;
  assign ex_mem.result_src = id_ex.result_src;
  assign ex_mem.reg_write  = id_ex.reg_write;
  assign ex_mem.mem_write  = id_ex.mem_write;

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps
`include "riscv_settings.svh"

// decode, immediates and register file
module decode_stage
  import riscv_pkg::*;
(
    input  logic     clk
  , input  logic     reset
  , input  if_id_t   if_id
  , input  logic     wb_write
  , input  reg_idx_t wb_rd
  , input  word_t    wb_result
  , output reg_idx_t rs1
  , output reg_idx_t rs2
  , output id_ex_t   id_ex
);

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;

  word_t      regs [`RISCV_NUM_REGS];
  word_t      instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_b5;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  logic       uses_rs1;
  logic       uses_rs2;

  assign instr     = if_id.instr;
  assign opcode    = instr[6:0];
  assign funct3    = instr[14:12];
  assign funct7_b5 = instr[30];

  // immediate formats, all sign extended from bit 31
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // register file, written at the end of write-back
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RISCV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_write) begin
      regs[wb_rd] <= wb_result;
    end
  end

  // unused source fields go to x0 so the hazard unit ignores them
  assign rs1 = uses_rs1 ? instr[19:15] : '0;
  assign rs2 = uses_rs2 ? instr[24:20] : '0;

  // x0 reads zero, a same-cycle write bypasses the array
  assign id_ex.rs1_data = (rs1 == '0) ? '0 :
                          (wb_write && wb_rd == rs1) ? wb_result : regs[rs1];
  assign id_ex.rs2_data = (rs2 == '0) ? '0 :
                          (wb_write && wb_rd == rs2) ? wb_result : regs[rs2];

  assign id_ex.pc       = if_id.pc;
  assign id_ex.pc_plus4 = if_id.pc_plus4;
  assign id_ex.rs1      = rs1;
  assign id_ex.rs2      = rs2;

  always_comb begin
    // anything unrecognized falls through as a nop
    uses_rs1         = 1'b0;
    uses_rs2         = 1'b0;
    id_ex.imm        = '0;
    id_ex.rd         = '0;
    id_ex.alu_op     = ALU_ADD;
    id_ex.alu_src    = 1'b0;
    id_ex.result_src = RES_ALU;
    id_ex.reg_write  = 1'b0;
    id_ex.mem_write  = 1'b0;
    id_ex.branch     = 1'b0;
    id_ex.branch_ne  = 1'b0;
    id_ex.jump       = 1'b0;
    case (opcode)
      OP_LUI: begin
        // x0 + upper immediate
        id_ex.imm       = imm_u;
        id_ex.alu_src   = 1'b1;
        id_ex.rd        = instr[11:7];
        id_ex.reg_write = 1'b1;
      end
      OP_JAL: begin
        id_ex.imm        = imm_j;
        id_ex.rd         = instr[11:7];
        id_ex.result_src = RES_PC_PLUS4;
        id_ex.reg_write  = 1'b1;
        id_ex.jump       = 1'b1;
      end
      OP_BRANCH: begin
        if (funct3 == 3'b000 || funct3 == 3'b001) begin
          uses_rs1        = 1'b1;
          uses_rs2        = 1'b1;
          id_ex.imm       = imm_b;
          id_ex.branch    = 1'b1;
          id_ex.branch_ne = funct3[0];
        end
      end
      OP_LOAD: begin
        // lw only, address = rs1 + offset
        uses_rs1         = 1'b1;
        id_ex.imm        = imm_i;
        id_ex.alu_src    = 1'b1;
        id_ex.rd         = instr[11:7];
        id_ex.result_src = RES_LOAD;
        id_ex.reg_write  = 1'b1;
      end
      OP_STORE: begin
        uses_rs1        = 1'b1;
        uses_rs2        = 1'b1;
        id_ex.imm       = imm_s;
        id_ex.alu_src   = 1'b1;
        id_ex.mem_write = 1'b1;
      end
      OP_IMM: begin
        uses_rs1        = 1'b1;
        id_ex.imm       = imm_i;
        id_ex.alu_src   = 1'b1;
        id_ex.rd        = instr[11:7];
        id_ex.reg_write = 1'b1;
        case (funct3)
          3'b000:  id_ex.alu_op = ALU_ADD;
          3'b010:  id_ex.alu_op = ALU_SLT;
          3'b100:  id_ex.alu_op = ALU_XOR;
          3'b110:  id_ex.alu_op = ALU_OR;
          3'b111:  id_ex.alu_op = ALU_AND;
          // shifts not supported
          default: id_ex.reg_write = 1'b0;
        endcase
      end
      OP_REG: begin
        uses_rs1        = 1'b1;
        uses_rs2        = 1'b1;
        id_ex.rd        = instr[11:7];
        id_ex.reg_write = 1'b1;
        case (funct3)
          3'b000:  id_ex.alu_op = funct7_b5 ? ALU_SUB : ALU_ADD;
          3'b010:  id_ex.alu_op = ALU_SLT;
          3'b100:  id_ex.alu_op = ALU_XOR;
          3'b110:  id_ex.alu_op = ALU_OR;
          3'b111:  id_ex.alu_op = ALU_AND;
          default: id_ex.reg_write = 1'b0;
        endcase
      end
      default: begin
        id_ex.reg_write = 1'b0;
      end
    endcase
  end

endmodule

//--- design/fetch_stage.sv
`timescale 1ns/1ps
`include "riscv_settings.svh"

// program counter and instruction fetch
module fetch_stage
  import riscv_pkg::*;
(
    input  logic   clk
  , input  logic   reset
  , input  logic   stall
  , input  logic   branch_taken
  , input  addr_t  branch_target
  , output addr_t  instr_address
  , input  word_t  instr_data
  , output if_id_t if_id
);

  addr_t pc;
  addr_t pc_plus4;

  assign pc_plus4 = pc + 32'd4;

  // taken branch wins, it also cancels whatever caused a stall
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RISCV_RESET_PC;
    end else if (branch_taken) begin
      pc <= branch_target;
    end else if (!stall) begin
      pc <= pc_plus4;
    end
  end

  // instruction port reads combinationally
  assign instr_address = pc;

  assign if_id.pc       = pc;
  assign if_id.pc_plus4 = pc_plus4;
  assign if_id.instr    = instr_data;

endmodule

//--- design/pipe_register.sv
`timescale 1ns/1ps

// one pipeline stage boundary, payload type set per instance
module pipe_register #(
  parameter type payload_t = logic [31:0]
) (
    input  logic     clk
  , input  logic     reset
  , input  logic     stall
  , input  logic     flush
  , input  payload_t d
  , output payload_t q
);

  // all-zero payload is a bubble
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      q <= '0;
    end else if (!stall) begin
      q <= d;
    end
  end

endmodule

//--- design/riscv_pkg.sv
package riscv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;

  // alu operations, add is zero so a bubble is harmless
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5
  } alu_op_t;

  // what write-back returns to the register file
  typedef enum logic [1:0] {
    RES_ALU      = 2'd0,
    RES_LOAD     = 2'd1,
    RES_PC_PLUS4 = 2'd2
  } result_src_t;

  // fetch to decode, 96 bits
  typedef struct packed {
    addr_t pc;
    addr_t pc_plus4;
    word_t instr;
  } if_id_t;

  // decode to execute
  typedef struct packed {
    addr_t       pc;
    addr_t       pc_plus4;
    word_t       rs1_data;
    word_t       rs2_data;
    word_t       imm;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    alu_op_t     alu_op;
    // operand b from the immediate
    logic        alu_src;
    result_src_t result_src;
    logic        reg_write;
    logic        mem_write;
    logic        branch;
    // branch when not equal (bne)
    logic        branch_ne;
    logic        jump;
  } id_ex_t;

  // execute to memory
  typedef struct packed {
    word_t       alu_result;
    word_t       store_data;
    addr_t       pc_plus4;
    reg_idx_t    rd;
    result_src_t result_src;
    logic        reg_write;
    logic        mem_write;
  } ex_mem_t;

  // memory to write-back
  typedef struct packed {
    word_t       alu_result;
    word_t       load_data;
    addr_t       pc_plus4;
    reg_idx_t    rd;
    result_src_t result_src;
    logic        reg_write;
  } mem_wb_t;

endpackage

//--- design/riscv_settings.svh
`ifndef RISCV_SETTINGS_SVH
`define RISCV_SETTINGS_SVH

// first instruction fetched out of reset
`define RISCV_RESET_PC 32'h0000_0000

// architectural integer registers, x0 included
`define RISCV_NUM_REGS 32

`endif
